/* sources.f */
+incdir+src
src/vcore_pkg.sv
src/vec_decoder.sv
src/cmd_queue.sv
src/vec_lanes.sv
src/vector_core.sv
dv/vector_core_tb.sv

/* dv/vector_core_tb.sv */
`default_nettype none

`include "vcore_macros.svh"

module vector_core_tb;
   import vcore_pkg::*;

   localparam int TIMEOUT = 400;

   logic        clk;
   logic        reset_i;
   logic        instr_valid_i;
   logic [31:0] vector_instr_i;
   logic [31:0] rs1_i;
   logic [31:0] rs2_i;
   logic        vector_stall_o;
   logic [31:0] ctrl_waddr_offset_o;
   logic [31:0] ctrl_wxfer_size_o;
   logic        ctrl_wstart_o;
   logic        ctrl_wdone_i;
   logic [31:0] wr_tdata_o;
   logic        wr_tvalid_o;
   logic        wr_tready_i;

   logic [31:0] model [`VREG_NUM][`VLANE_NUM];   // Reference register file
   logic [31:0] exp_addr [$];                   // One entry per accepted store
   logic [31:0] exp_words [$];
   logic [31:0] cur_words [`VLANE_NUM];
   logic [31:0] start_addr;
   integer      seed;
   integer      port_seed;
   int          value_errs;
   int          proto_errs;
   int          beat_idx;
   int          done_cnt;
   bit          storing;
   bit          need_done;
   bit          stall_seen;

   vector_core uut
     (
      .clk_i               (clk),
      .reset_i             (reset_i),
      .instr_valid_i       (instr_valid_i),
      .vector_instr_i      (vector_instr_i),
      .rs1_i               (rs1_i),
      .rs2_i               (rs2_i),
      .vector_stall_o      (vector_stall_o),
      .ctrl_waddr_offset_o (ctrl_waddr_offset_o),
      .ctrl_wxfer_size_o   (ctrl_wxfer_size_o),
      .ctrl_wstart_o       (ctrl_wstart_o),
      .ctrl_wdone_i        (ctrl_wdone_i),
      .wr_tdata_o          (wr_tdata_o),
      .wr_tvalid_o         (wr_tvalid_o),
      .wr_tready_i         (wr_tready_i)
      );

   always #20 clk = ~clk;

   // Beat data and valid hold while the port is stalled
   assert property (@(posedge clk) disable iff (reset_i)
                    wr_tvalid_o && !wr_tready_i |=> wr_tvalid_o)
   else
   begin
      proto_errs++;
      $display("Fail wr_tvalid_o expected 1 got %h", $sampled(wr_tvalid_o));
   end

   assert property (@(posedge clk) disable iff (reset_i)
                    wr_tvalid_o && !wr_tready_i |=> $stable(wr_tdata_o))
   else
   begin
      proto_errs++;
      $display("Fail wr_tdata_o expected %h got %h", $past(wr_tdata_o),
               $sampled(wr_tdata_o));
   end

   function automatic logic [31:0] make_instr(input logic [3:0] op, input int vd,
                                              input int vs1, input int vs2);
      logic [31:0] instr;
      instr                    = '0;
      instr[`VOP_HI:`VOP_LO]   = op;
      instr[`VD_HI:`VD_LO]     = vd[`VREG_AW-1:0];
      instr[`VS1_HI:`VS1_LO]   = vs1[`VREG_AW-1:0];
      instr[`VS2_HI:`VS2_LO]   = vs2[`VREG_AW-1:0];
      return instr;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Error counts: %0d value, %0d protocol", value_errs, proto_errs);
      $display("RESULT: FAIL");
      $finish;
   endtask

   task automatic expect_low(input string name, input logic value);
      assert (value == 1'b0)
      else
      begin
         value_errs++;
         $display("Fail %s expected 0 got %h", name, value);
      end
   endtask

   // Scalar core driver that holds the instruction while stalled
   task automatic offer(input logic [3:0] op, input int vd, input int vs1, input int vs2,
                        input logic [31:0] rs1);
      int waited;
      waited = 0;
      @(negedge clk);
      vector_instr_i = make_instr(op, vd, vs1, vs2);
      rs1_i          = rs1;
      rs2_i          = $random(seed);
      instr_valid_i  = 1'b1;
      @(posedge clk);
      while (vector_stall_o)
      begin
         waited++;
         if (waited > TIMEOUT)
            abort_run("Instruction was never accepted, stall stayed high");
         @(posedge clk);
      end
      @(negedge clk);
      instr_valid_i = 1'b0;
   endtask

   task automatic drain_stores();
      int waited;
      waited = 0;
      while (exp_addr.size() != 0 || storing)
      begin
         waited++;
         if (waited > 4 * TIMEOUT)
            abort_run("Pending stores did not complete in time");
         @(posedge clk);
      end
   endtask

   // Reference model updated at instruction acceptance
   always @(posedge clk)
   begin : ref_model
      logic [31:0] res [`VLANE_NUM];
      logic [3:0]  op;
      int          vd;
      int          vs1;
      int          vs2;
      if (!reset_i && instr_valid_i && !vector_stall_o)
      begin
         op  = vector_instr_i[`VOP_HI:`VOP_LO];
         vd  = vector_instr_i[`VD_HI:`VD_LO];
         vs1 = vector_instr_i[`VS1_HI:`VS1_LO];
         vs2 = vector_instr_i[`VS2_HI:`VS2_LO];
         for (int l = 0; l < `VLANE_NUM; l++)
         begin
            case (op)
               OP_VADD_VV: res[l] = model[vs1][l] + model[vs2][l];
               OP_VSUB_VV: res[l] = model[vs1][l] - model[vs2][l];
               OP_VAND_VV: res[l] = model[vs1][l] & model[vs2][l];
               OP_VOR_VV:  res[l] = model[vs1][l] | model[vs2][l];
               OP_VXOR_VV: res[l] = model[vs1][l] ^ model[vs2][l];
               OP_VADD_VX: res[l] = model[vs2][l] + rs1_i;
               OP_VMV_VX:  res[l] = rs1_i;
               default:    res[l] = model[vd][l];   // Store and illegal codes leave vd
            endcase
         end
         if (op == OP_VSTORE)
         begin
            exp_addr.push_back(rs1_i);
            for (int l = 0; l < `VLANE_NUM; l++)
               exp_words.push_back(model[vs2][l]);
         end
         for (int l = 0; l < `VLANE_NUM; l++)
            model[vd][l] = res[l];
      end
   end

   // Write-port monitor
   always @(posedge clk)
   begin : port_monitor
      if (!reset_i)
      begin
         if (vector_stall_o)
            stall_seen = 1'b1;
         if (storing)
         begin
            assert (ctrl_waddr_offset_o == start_addr)
            else
            begin
               value_errs++;
               $display("Fail ctrl_waddr_offset_o expected %h got %h",
                        start_addr, ctrl_waddr_offset_o);
            end
            assert (ctrl_wxfer_size_o == 32'h10)
            else
            begin
               value_errs++;
               $display("Fail ctrl_wxfer_size_o expected %h got %h", 32'h10,
                        ctrl_wxfer_size_o);
            end
         end
         if (ctrl_wdone_i)
            storing = 1'b0;
         if (wr_tvalid_o)
         begin
            assert (storing && beat_idx < `VLANE_NUM)
            else
            begin
               proto_errs++;
               $display("Write beat seen outside a started store");
            end
         end
         if (wr_tvalid_o && wr_tready_i && storing && beat_idx < `VLANE_NUM)
         begin
            assert (wr_tdata_o == cur_words[beat_idx])
            else
            begin
               value_errs++;
               $display("Fail wr_tdata_o beat %0d expected %h got %h",
                        beat_idx, cur_words[beat_idx], wr_tdata_o);
            end
            beat_idx++;
            need_done = (beat_idx == `VLANE_NUM);
         end
         if (ctrl_wstart_o)
         begin
            assert (!storing && exp_addr.size() > 0)
            else
            begin
               proto_errs++;
               $display("Write start seen with no store pending");
            end
            if (exp_addr.size() > 0)
            begin
               start_addr = exp_addr.pop_front();
               assert (ctrl_waddr_offset_o == start_addr)
               else
               begin
                  value_errs++;
                  $display("Fail ctrl_waddr_offset_o expected %h got %h",
                           start_addr, ctrl_waddr_offset_o);
               end
               assert (ctrl_wxfer_size_o == 32'h10)
               else
               begin
                  value_errs++;
                  $display("Fail ctrl_wxfer_size_o expected %h got %h", 32'h10,
                           ctrl_wxfer_size_o);
               end
               for (int l = 0; l < `VLANE_NUM; l++)
                  cur_words[l] = exp_words.pop_front();
               storing  = 1'b1;
               beat_idx = 0;
            end
         end
      end
   end

   // Write-port driver with random ready gaps and a late done
   always @(negedge clk)
   begin : port_driver
      wr_tready_i  = ($random(port_seed) & 3) != 0;   // Roughly one gap in four
      ctrl_wdone_i = 1'b0;
      if (need_done)
      begin
         need_done = 1'b0;
         done_cnt  = $random(port_seed) & 3;
      end
      else if (done_cnt > 0)
         done_cnt--;
      if (done_cnt == 0)
      begin
         ctrl_wdone_i = 1'b1;
         done_cnt     = -1;
      end
   end

   initial
   begin
      seed           = 32'h6fb6_b6d3;
      port_seed      = seed ^ 32'h0000_ffff;
      clk            = 1'b0;
      reset_i        = 1'b1;
      instr_valid_i  = 1'b0;
      vector_instr_i = '0;
      rs1_i          = '0;
      rs2_i          = '0;
      wr_tready_i    = 1'b1;
      ctrl_wdone_i   = 1'b0;
      value_errs     = 0;
      proto_errs     = 0;
      beat_idx       = 0;
      done_cnt       = -1;
      storing        = 1'b0;
      need_done      = 1'b0;
      stall_seen     = 1'b0;
      start_addr     = '0;
      for (int r = 0; r < `VREG_NUM; r++)
         for (int l = 0; l < `VLANE_NUM; l++)
            model[r][l] = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;

      // Idle outputs and a zero register after reset
      expect_low("vector_stall_o", vector_stall_o);
      expect_low("ctrl_wstart_o", ctrl_wstart_o);
      expect_low("wr_tvalid_o", wr_tvalid_o);
      offer(OP_VSTORE, 0, 0, 3, $random(seed));
      drain_stores();

      // Scalar loads
      offer(OP_VMV_VX, 1, 0, 0, $random(seed));
      offer(OP_VMV_VX, 2, 0, 0, $random(seed));
      offer(OP_VADD_VX, 3, 0, 1, $random(seed));
      offer(OP_VSTORE, 0, 0, 1, $random(seed));
      offer(OP_VSTORE, 0, 0, 2, $random(seed));
      offer(OP_VSTORE, 0, 0, 3, $random(seed));
      drain_stores();

      // Vector-vector ops with a small v5 so sub wraps
      offer(OP_VMV_VX, 5, 0, 0, 32'h5);
      offer(OP_VMV_VX, 6, 0, 0, $random(seed) | 32'h8000_0000);
      for (int k = 1; k <= 5; k++)
      begin
         offer(4'(k), 4, 5, 6, 0);
         offer(OP_VSTORE, 0, 0, 4, $random(seed));
         offer(4'(k), 7, 1, 3, 0);
         offer(OP_VSTORE, 0, 0, 7, $random(seed));
      end
      offer(4'hf, 4, 1, 2, $random(seed));   // Illegal codes
      offer(4'h0, 4, 1, 2, $random(seed));
      offer(4'h9, 4, 1, 2, $random(seed));
      offer(OP_VSTORE, 0, 0, 4, $random(seed));
      drain_stores();

      // Back-to-back stores against a slow port
      for (int k = 0; k < 12; k++)
      begin
         if (k % 3 == 2)
            offer(OP_VMV_VX, $random(seed) & 7, 0, 0, $random(seed));
         offer(OP_VSTORE, 0, 0, $random(seed) & 7, $random(seed));
      end
      drain_stores();
      assert (stall_seen)
      else
      begin
         proto_errs++;
         $display("Stall never rose while stores were queued");
      end

      repeat (20) @(posedge clk);   // Room for any stray start or beat
      $display("Error counts: %0d value, %0d protocol", value_errs, proto_errs);
      if (value_errs + proto_errs == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* src/vector_core.sv */
`default_nettype none

module vector_core
  (
   input  logic        clk_i,
   input  logic        reset_i,
   // Scalar core side
   input  logic        instr_valid_i,
   input  logic [31:0] vector_instr_i,
   input  logic [31:0] rs1_i,
   input  logic [31:0] rs2_i,
   output logic        vector_stall_o,
   // Write channel toward the AXI master
   output logic [31:0] ctrl_waddr_offset_o,
   output logic [31:0] ctrl_wxfer_size_o,
   output logic        ctrl_wstart_o,
   input  logic        ctrl_wdone_i,
   output logic [31:0] wr_tdata_o,
   output logic        wr_tvalid_o,
   input  logic        wr_tready_i
   );
   import vcore_pkg::*;

   logic             q_push;
   logic [CMD_W-1:0] q_cmd;
   logic             q_full;
   logic             q_empty;
   logic [CMD_W-1:0] q_head;
   logic             q_pop;

   vec_decoder vec_decoder_inst
     (
      .instr_valid_i  (instr_valid_i),
      .vector_instr_i (vector_instr_i),
      .rs1_i          (rs1_i),
      .rs2_i          (rs2_i),
      .queue_full_i   (q_full),
      .vector_stall_o (vector_stall_o),
      .push_o         (q_push),
      .cmd_o          (q_cmd)
      );

   cmd_queue cmd_queue_inst
     (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (q_push),
      .cmd_i   (q_cmd),
      .pop_i   (q_pop),
      .head_o  (q_head),
      .empty_o (q_empty),
      .full_o  (q_full)
      );

   vec_lanes vec_lanes_inst
     (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .empty_i             (q_empty),
      .head_i              (q_head),
      .pop_o               (q_pop),
      .ctrl_waddr_offset_o (ctrl_waddr_offset_o),
      .ctrl_wxfer_size_o   (ctrl_wxfer_size_o),
      .ctrl_wstart_o       (ctrl_wstart_o),
      .ctrl_wdone_i        (ctrl_wdone_i),
      .wr_tdata_o          (wr_tdata_o),
      .wr_tvalid_o         (wr_tvalid_o),
      .wr_tready_i         (wr_tready_i)
      );

endmodule

`default_nettype wire

/* src/vec_lanes.sv */
`default_nettype none

`include "vcore_macros.svh"

module vec_lanes
  (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        empty_i,
   input  logic [vcore_pkg::CMD_W-1:0] head_i,
   output logic                        pop_o,
   output logic [31:0]                 ctrl_waddr_offset_o,
   output logic [31:0]                 ctrl_wxfer_size_o,
   output logic                        ctrl_wstart_o,
   input  logic                        ctrl_wdone_i,
   output logic [31:0]                 wr_tdata_o,
   output logic                        wr_tvalid_o,
   input  logic                        wr_tready_i
   );
   import vcore_pkg::*;

   localparam int          BEAT_W     = $clog2(`VLANE_NUM);
   localparam logic [31:0] XFER_BYTES = 32'(`VLANE_NUM * 4);

   // Register file, one 32-bit word per lane
   logic [`VLANE_NUM-1:0][31:0] vrf [`VREG_NUM];

   // Head of queue
   logic [3:0]          head_opc;
   vec_op_e             head_op;
   logic [`VREG_AW-1:0] head_vd;
   logic [`VREG_AW-1:0] head_vs1;
   logic [`VREG_AW-1:0] head_vs2;
   logic [31:0]         head_scalar;

   // Command in execution
   vec_op_e             cur_op;
   logic [`VREG_AW-1:0] cur_vd;
   logic [`VREG_AW-1:0] cur_vs1;
   logic [`VREG_AW-1:0] cur_vs2;
   logic [31:0]         cur_scalar;

   logic [`VLANE_NUM-1:0][31:0] src1;
   logic [`VLANE_NUM-1:0][31:0] src2;
   logic [`VLANE_NUM-1:0][31:0] alu_res;
   logic [`VLANE_NUM-1:0][31:0] st_data;   // Store snapshot of vs2

   lane_state_e       state_q;
   lane_state_e       state_d;
   logic [BEAT_W-1:0] beat_cnt;
   logic              beat_fire;
   logic              last_beat;

   function automatic logic [31:0] lane_alu(input vec_op_e     op,
                                            input logic [31:0] a,
                                            input logic [31:0] b,
                                            input logic [31:0] x);
      case (op)
         OP_VADD_VV: lane_alu = a + b;
         OP_VSUB_VV: lane_alu = a - b;   // Wraps modulo 2^32
         OP_VAND_VV: lane_alu = a & b;
         OP_VOR_VV:  lane_alu = a | b;
         OP_VXOR_VV: lane_alu = a ^ b;
         OP_VADD_VX: lane_alu = b + x;
         OP_VMV_VX:  lane_alu = x;
         default:    lane_alu = '0;
      endcase
   endfunction

   assign {head_opc, head_vd, head_vs1, head_vs2, head_scalar} = head_i;
   assign head_op = vec_op_e'(head_opc);

   assign pop_o = (state_q == LS_IDLE) && !empty_i;

   // One ALU per lane
   assign src1 = vrf[cur_vs1];
   assign src2 = vrf[cur_vs2];

   always_comb
   begin
      for (int l = 0; l < `VLANE_NUM; l++)
      begin
         alu_res[l] = lane_alu(cur_op, src1[l], src2[l], cur_scalar);
      end
   end

   // Write port
   assign ctrl_wstart_o       = (state_q == LS_START);
   assign ctrl_waddr_offset_o = cur_scalar;   // Stable until next pop
   assign ctrl_wxfer_size_o   = XFER_BYTES;
   assign wr_tvalid_o         = (state_q == LS_STREAM);
   assign wr_tdata_o          = st_data[beat_cnt];   // Lane 0 first
   assign beat_fire           = wr_tvalid_o && wr_tready_i;
   assign last_beat           = (beat_cnt == BEAT_W'(`VLANE_NUM - 1));

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         LS_IDLE:
         begin
            if (!empty_i)
               state_d = (head_op == OP_VSTORE) ? LS_START : LS_EXEC;
         end
         LS_EXEC:   state_d = LS_IDLE;
         LS_START:  state_d = LS_STREAM;
         LS_STREAM:
         begin
            if (beat_fire && last_beat)
               state_d = LS_WAIT_DONE;
         end
         LS_WAIT_DONE:
         begin
            if (ctrl_wdone_i)
               state_d = LS_IDLE;
         end
         default:   state_d = LS_IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q  <= LS_IDLE;
         beat_cnt <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == LS_START)
            beat_cnt <= '0;
         else if (beat_fire)
            beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // Take the head on pop
   always_ff @(posedge clk_i)
   begin
      if (pop_o)
      begin
         cur_op     <= head_op;
         cur_vd     <= head_vd;
         cur_vs1    <= head_vs1;
         cur_vs2    <= head_vs2;
         cur_scalar <= head_scalar;
         st_data    <= vrf[head_vs2];
      end
   end

   // Result lands one cycle after the pop
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         for (int r = 0; r < `VREG_NUM; r++)
         begin
            vrf[r] <= '0;
         end
      end
      else if (state_q == LS_EXEC)
      begin
         vrf[cur_vd] <= alu_res;
      end
   end

endmodule

`default_nettype wire

/* src/cmd_queue.sv */
`default_nettype none

`include "vcore_macros.svh"

module cmd_queue
  (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        push_i,
   input  logic [vcore_pkg::CMD_W-1:0] cmd_i,
   input  logic                        pop_i,
   output logic [vcore_pkg::CMD_W-1:0] head_o,
   output logic                        empty_o,
   output logic                        full_o
   );
   import vcore_pkg::*;

   localparam int PTR_W = $clog2(`VQ_DEPTH);
   localparam int CNT_W = $clog2(`VQ_DEPTH + 1);

   logic [CMD_W-1:0] mem [`VQ_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign empty_o = (count == '0);
   assign full_o  = (count == CNT_W'(`VQ_DEPTH));

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;   // Pop on empty is ignored

   // Show-ahead head entry
   assign head_o = mem[rd_ptr];

   always_ff @(posedge clk_i)
   begin
      if (do_push)
         mem[wr_ptr] <= cmd_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(`VQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(`VQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/vec_decoder.sv */
`default_nettype none

`include "vcore_macros.svh"

module vec_decoder
  (
   input  logic                        instr_valid_i,
   input  logic [31:0]                 vector_instr_i,
   input  logic [31:0]                 rs1_i,
   input  logic [31:0]                 rs2_i,    // No current opcode reads it
   input  logic                        queue_full_i,
   output logic                        vector_stall_o,
   output logic                        push_o,
   output logic [vcore_pkg::CMD_W-1:0] cmd_o
   );
   import vcore_pkg::*;

   logic [`VOP_HI-`VOP_LO:0] opcode;
   logic [`VREG_AW-1:0]      vd;
   logic [`VREG_AW-1:0]      vs1;
   logic [`VREG_AW-1:0]      vs2;
   logic                     op_legal;
   logic                     accept;
   logic [31:0]              scalar;

   // Field extraction
   assign opcode = vector_instr_i[`VOP_HI:`VOP_LO];
   assign vd     = vector_instr_i[`VD_HI:`VD_LO];
   assign vs1    = vector_instr_i[`VS1_HI:`VS1_LO];
   assign vs2    = vector_instr_i[`VS2_HI:`VS2_LO];

   // Every opcode of this unit takes rs1 as its scalar operand;
   // rs2 stays at the pin for future two-scalar forms
   assign scalar = rs1_i;

   always_comb
   begin
      case (vec_op_e'(opcode))
         OP_VADD_VV,
         OP_VSUB_VV,
         OP_VAND_VV,
         OP_VOR_VV,
         OP_VXOR_VV,
         OP_VADD_VX,
         OP_VMV_VX,
         OP_VSTORE:  op_legal = 1'b1;
         default:    op_legal = 1'b0;  // Dropped silently
      endcase
   end

   // Core holds the instruction while stalled
   assign vector_stall_o = queue_full_i;
   assign accept         = instr_valid_i && !queue_full_i;

   assign push_o = accept && op_legal;
   assign cmd_o  = {opcode, vd, vs1, vs2, scalar};

endmodule

`default_nettype wire

/* src/vcore_pkg.sv */
`default_nettype none

`include "vcore_macros.svh"

package vcore_pkg;

   // Vector opcodes, all other codes are illegal
   typedef enum logic [3:0] {
      OP_VADD_VV = 4'd1,
      OP_VSUB_VV = 4'd2,  // vs1 - vs2
      OP_VAND_VV = 4'd3,
      OP_VOR_VV  = 4'd4,
      OP_VXOR_VV = 4'd5,
      OP_VADD_VX = 4'd6,  // vs2 + rs1
      OP_VMV_VX  = 4'd7,  // rs1 into every lane
      OP_VSTORE  = 4'd8   // vs2 out to address rs1
   } vec_op_e;

   // Execution unit states
   typedef enum logic [2:0] {
      LS_IDLE,
      LS_EXEC,
      LS_START,
      LS_STREAM,
      LS_WAIT_DONE
   } lane_state_e;

   // Packed command is {opcode, vd, vs1, vs2, scalar}
   localparam int CMD_W = (`VOP_HI - `VOP_LO + 1) + 3 * `VREG_AW + 32;

endpackage

`default_nettype wire

/* src/vcore_macros.svh */
`ifndef VCORE_MACROS_SVH
`define VCORE_MACROS_SVH

// Vector unit geometry
`define VLANE_NUM 4
`define VREG_NUM  8
`define VREG_AW   3
`define VQ_DEPTH  4

// Instruction field positions
`define VOP_HI  31
`define VOP_LO  28
`define VS2_HI  22
`define VS2_LO  20
`define VS1_HI  17
`define VS1_LO  15
`define VD_HI   9
`define VD_LO   7

`endif
